// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= rename_tb
FILELIST  ?= src.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert
PASS_MSG  ?= Simulation finished: PASS

SOURCES := $(wildcard include/*.svh verilog/*.sv verification/*.sv)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# the log decides, the simulator exit code is not trusted
sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== include/rename_params.svh ====
`ifndef RENAME_PARAMS_SVH
`define RENAME_PARAMS_SVH

// rename group size, instructions renamed per cycle
`define RN_WIDTH 2

// architectural register file
`define ARCH_REG_SZ 32
`define ARCH_REG_ID_BITS 5 // clog2(ARCH_REG_SZ)

// physical register file, free and complete lists have one bit per entry
`define PHYS_REG_SZ 64
`define PHYS_REG_ID_BITS 6 // clog2(PHYS_REG_SZ)

// counts 0..RN_WIDTH, so one bit wider than a slot index
`define RN_CNT_BITS 2

`endif

// ==== src.f ====
+incdir+include
verilog/rename_pkg.sv
verilog/free_reg_picker.sv
verilog/reg_status_lists.sv
verilog/map_table.sv
verilog/rename_stage.sv
verilog/rename_top.sv
verification/rename_asserts.sv
verification/rename_tb.sv

// ==== verification/rename_asserts.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// status list properties, bound into reg_status_lists
module rename_asserts
    import rename_pkg::*;
(
    input logic                          clock,
    input logic                          reset,
    input phys_reg_vec_t                 free_list,
    input phys_reg_vec_t                 complete_list,
    input phys_reg_vec_t                 updated_free_list,
    input phys_reg_vec_t                 free_list_restore,
    input logic                          restore_flag,
    input phys_reg_idx_t [`RN_WIDTH-1:0] retiring_reg,
    input rn_cnt_t                       num_retiring
);

    int            assert_fail_count = 0; // summed into the testbench verdict
    phys_reg_vec_t returned_regs;         // may legally come back as free
    phys_reg_vec_t pinned_regs;           // allocated this cycle and not handed back

    always_comb begin
        returned_regs = restore_flag ? free_list_restore : '0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (s < int'(num_retiring)) begin
                returned_regs[retiring_reg[s]] = 1'b1;
            end
        end
        pinned_regs = free_list & ~updated_free_list & ~returned_regs;
    end

    // arch regs hold committed values out of reset
    complete_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> &complete_list[`ARCH_REG_SZ-1:0])
        else begin
            $error("lower complete bits not all set after reset");
            assert_fail_count++;
        end

    alloc_stays_taken: assert property (@(posedge clock) disable iff (reset)
        (free_list & $past(pinned_regs)) == '0)
        else begin
            $error("allocated register is free again without retire or restore");
            assert_fail_count++;
        end

    // arch regs are mapped, so none of them may be free yet
    no_low_free_after_reset: assert property (@(posedge clock)
        $fell(reset) |-> free_list[`ARCH_REG_SZ-1:0] == '0)
        else begin
            $error("free list holds architectural registers after reset");
            assert_fail_count++;
        end

endmodule

bind reg_status_lists rename_asserts u_status_asserts (
    .clock             (clock),
    .reset             (reset),
    .free_list         (free_list),
    .complete_list     (complete_list),
    .updated_free_list (updated_free_list),
    .free_list_restore (free_list_restore),
    .restore_flag      (restore_flag),
    .retiring_reg      (retiring_reg),
    .num_retiring      (num_retiring)
);

`default_nettype wire

// ==== verification/rename_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

module rename_tb
    import rename_pkg::*;
();

    localparam int reset_cycles  = 16;
    localparam int random_cycles = 300;
    localparam int cycle_limit   =                       // every test plus slack
        reset_cycles + `ARCH_REG_SZ + `PHYS_REG_SZ + random_cycles + 100;

    logic                          clock;
    logic                          reset;
    logic          [`RN_WIDTH-1:0] dispatch_valid;
    arch_reg_idx_t [`RN_WIDTH-1:0] dest_arch;
    logic                          dispatch_ready;
    phys_reg_idx_t [`RN_WIDTH-1:0] t_new;
    phys_reg_idx_t [`RN_WIDTH-1:0] t_old;
    logic          [`RN_WIDTH-1:0] completing_valid;
    phys_reg_idx_t [`RN_WIDTH-1:0] completing_reg;
    phys_reg_idx_t [`RN_WIDTH-1:0] retiring_reg;
    rn_cnt_t                       num_retiring;
    logic                          restore_flag;
    phys_reg_vec_t                 free_list_restore;
    phys_reg_vec_t                 free_list;
    phys_reg_vec_t                 complete_list;
    phys_reg_vec_t                 next_complete_list;

    phys_reg_vec_t model_free;                // model state, advanced at each rising edge
    phys_reg_vec_t model_complete;
    phys_reg_idx_t model_map [`ARCH_REG_SZ];
    phys_reg_idx_t live_q [$];                // allocated T_new, completion candidates
    phys_reg_idx_t old_q [$];                 // T_old in dispatch order, retire candidates

    logic                          exp_ready;
    phys_reg_idx_t [`RN_WIDTH-1:0] exp_new;
    phys_reg_idx_t [`RN_WIDTH-1:0] exp_old;
    phys_reg_vec_t                 exp_free;
    phys_reg_vec_t                 exp_complete;
    logic                          older_valid;

    string       test_name;
    int          test_errors;
    int          error_count;
    int          check_count;
    int          cycle_count;
    logic        checking;
    logic [31:0] rng;

    rename_top UUT (
        .clock              (clock),
        .reset              (reset),
        .dispatch_valid     (dispatch_valid),
        .dest_arch          (dest_arch),
        .dispatch_ready     (dispatch_ready),
        .t_new              (t_new),
        .t_old              (t_old),
        .completing_valid   (completing_valid),
        .completing_reg     (completing_reg),
        .retiring_reg       (retiring_reg),
        .num_retiring       (num_retiring),
        .restore_flag       (restore_flag),
        .free_list_restore  (free_list_restore),
        .free_list          (free_list),
        .complete_list      (complete_list),
        .next_complete_list (next_complete_list)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock; // 8 ns period
    end

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // index of the n-th set bit counting from bit 0, -1 if there is none
    function automatic int nth_free(input phys_reg_vec_t vec, input int n);
        int seen;
        seen = 0;
        for (int b = 0; b < `PHYS_REG_SZ; b++) begin
            if (vec[b]) begin
                if (seen == n) begin
                    return b;
                end
                seen++;
            end
        end
        return -1;
    endfunction

    // expected outputs and next state for the inputs now on the pins
    function automatic logic ref_rename(output phys_reg_idx_t [`RN_WIDTH-1:0] e_new,
                                        output phys_reg_idx_t [`RN_WIDTH-1:0] e_old,
                                        output phys_reg_vec_t e_free,
                                        output phys_reg_vec_t e_complete);
        int            pick;
        logic          ready;
        phys_reg_vec_t taken;
        ready = 1'b1;
        taken = '0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            pick     = nth_free(model_free, s);
            e_new[s] = (pick < 0) ? '0 : phys_reg_idx_t'(pick);
            if (dispatch_valid[s] && pick < 0) begin
                ready = 1'b0; // all slots or none
            end
            e_old[s] = model_map[dest_arch[s]];
            for (int j = 0; j < s; j++) begin
                if (dispatch_valid[j] && dest_arch[j] == dest_arch[s]) begin
                    e_old[s] = e_new[j]; // nearest older slot wins
                end
            end
        end
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (ready && dispatch_valid[s]) begin
                taken[e_new[s]] = 1'b1;
            end
        end
        e_free = model_free & ~taken;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (s < int'(num_retiring)) begin
                e_free[retiring_reg[s]] = 1'b1;
            end
        end
        if (restore_flag) begin
            e_free = e_free | free_list_restore;
        end
        e_complete = model_complete;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (completing_valid[s]) begin
                e_complete[completing_reg[s]] = 1'b1;
            end
        end
        e_complete = e_complete & ~taken;
        return ready;
    endfunction

    task automatic check_value(input string what, input phys_reg_vec_t expected,
                               input phys_reg_vec_t actual);
        check_count++;
        assert (actual === expected) else begin
            $display("ERR %s %s expected %h actual %h", test_name, what, expected, actual);
            error_count++;
            test_errors++;
        end
    endtask

    // compare at each rising edge, then step the model
    always @(posedge clock) begin
        if (!reset && checking) begin
            exp_ready = ref_rename(exp_new, exp_old, exp_free, exp_complete);
            check_value("dispatch_ready", phys_reg_vec_t'(exp_ready),
                        phys_reg_vec_t'(dispatch_ready));
            check_value("free_list", model_free, free_list);
            check_value("complete_list", model_complete, complete_list);
            check_value("next_complete_list", exp_complete, next_complete_list);
            for (int s = 0; s < `RN_WIDTH; s++) begin
                older_valid = 1'b0;
                for (int j = 0; j < s; j++) begin
                    older_valid = older_valid | dispatch_valid[j];
                end
                if (exp_ready && dispatch_valid[s]) begin
                    check_value($sformatf("t_new[%0d]", s), phys_reg_vec_t'(exp_new[s]),
                                phys_reg_vec_t'(t_new[s]));
                end
                if (exp_ready || !older_valid) begin // bypass source is only defined when ready
                    check_value($sformatf("t_old[%0d]", s), phys_reg_vec_t'(exp_old[s]),
                                phys_reg_vec_t'(t_old[s]));
                end
            end
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (exp_ready && dispatch_valid[s]) begin
                    model_map[dest_arch[s]] = exp_new[s]; // ascending, higher slot wins
                    live_q.push_back(exp_new[s]);
                    old_q.push_back(exp_old[s]);
                end
            end
            model_free     = exp_free;
            model_complete = exp_complete;
        end
    end

    task automatic drive_idle();
        dispatch_valid   = '0;
        completing_valid = '0;
        num_retiring     = '0;
        restore_flag     = 1'b0;
    endtask

    task automatic start_test(input string name);
        test_name   = name;
        test_errors = 0;
    endtask

    // one idle cycle so the last request and its effect both get compared
    task automatic finish_test();
        @(negedge clock);
        drive_idle();
        @(negedge clock);
        $display("test %s: %0d errors", test_name, test_errors);
    endtask

    task automatic random_cycle();
        rng = xorshift32(rng);
        drive_idle();
        for (int s = 0; s < `RN_WIDTH; s++) begin
            dispatch_valid[s] = (int'(rng[1:0]) > s); // packed from slot 0
            dest_arch[s]      = rng[2 + 5 * s +: 5];
            if (rng[20 + s] && live_q.size() > 0) begin
                completing_reg[s]   = live_q.pop_front();
                completing_valid[s] = !model_free[completing_reg[s]]; // skip restored regs
            end
        end
        if (rng[25:24] != 2'b00) begin
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (old_q.size() > 0) begin
                    retiring_reg[s] = old_q.pop_front();
                    num_retiring    = num_retiring + 1'b1;
                end
            end
        end
        if (rng[31:27] == 5'd0) begin // rare mispredict
            restore_flag      = 1'b1;
            free_list_restore = phys_reg_vec_t'({xorshift32(rng), 32'h0});
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clock);
            cycle_count++;
        end
        $display("timeout: no verdict after %0d cycles, stuck in test %s", cycle_count, test_name);
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        reset             = 1'b1;
        checking          = 1'b0;
        rng               = 32'h253;
        error_count       = 0;
        check_count       = 0;
        dest_arch         = '0;
        completing_reg    = '0;
        retiring_reg      = '0;
        free_list_restore = '0;
        drive_idle();
        for (int p = 0; p < `PHYS_REG_SZ; p++) begin
            model_free[p]     = (p >= `ARCH_REG_SZ); // upper half free
            model_complete[p] = (p < `ARCH_REG_SZ);
        end
        for (int r = 0; r < `ARCH_REG_SZ; r++) begin
            model_map[r] = phys_reg_idx_t'(r);
        end
        repeat (reset_cycles) @(posedge clock);
        @(negedge clock);
        reset    = 1'b0;
        checking = 1'b1;

        start_test("reset_state"); // walk every arch reg through the read ports
        for (int r = 0; r < `ARCH_REG_SZ; r++) begin
            @(negedge clock);
            for (int s = 0; s < `RN_WIDTH; s++) begin
                dest_arch[s] = arch_reg_idx_t'((r + 7 * s) % `ARCH_REG_SZ);
            end
        end
        finish_test();

        start_test("allocation");
        @(negedge clock);
        dispatch_valid = '1;
        dest_arch[0]   = 5'd3;
        dest_arch[1]   = 5'd5;
        @(negedge clock);
        dest_arch[0] = 5'd7; // same dest, slot 1 sees slot 0 T_new
        dest_arch[1] = 5'd7;
        @(negedge clock);
        dispatch_valid    = '0;
        dispatch_valid[0] = 1'b1;
        dest_arch[0]      = 5'd3;
        finish_test();

        start_test("completion");
        @(negedge clock);
        for (int s = 0; s < `RN_WIDTH; s++) begin
            completing_reg[s] = live_q.pop_front();
        end
        completing_valid = '1;
        finish_test();

        start_test("retire");
        @(negedge clock);
        for (int s = 0; s < `RN_WIDTH; s++) begin
            retiring_reg[s] = old_q.pop_front();
        end
        num_retiring = rn_cnt_t'(`RN_WIDTH);
        finish_test();

        start_test("back_pressure"); // drain, then hold a request that cannot be granted
        while ($countones(model_free) >= `RN_WIDTH) begin
            @(negedge clock);
            rng            = xorshift32(rng);
            dispatch_valid = '1;
            dest_arch[0]   = rng[4:0];
            dest_arch[1]   = rng[12:8];
        end
        repeat (4) @(negedge clock);
        finish_test();

        start_test("restore_random");
        @(negedge clock);
        rng               = xorshift32(rng);
        restore_flag      = 1'b1;
        free_list_restore = phys_reg_vec_t'({rng, 32'h0});
        repeat (random_cycles) begin
            @(negedge clock);
            random_cycle();
        end
        finish_test();

        error_count = error_count + UUT.u_lists.u_status_asserts.assert_fail_count;
        $display("summary: %0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verilog/free_reg_picker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// picks the RN_WIDTH lowest-numbered set bits of the free list
// purely combinational, grant i is the i-th lowest free register
module free_reg_picker
    import rename_pkg::*;
(
    input  phys_reg_vec_t                  req,        // free list
    output phys_reg_idx_t [`RN_WIDTH-1:0]  pick_reg,   // encoded grant per slot
    output logic          [`RN_WIDTH-1:0]  pick_valid  // grant exists for slot
);

    phys_reg_vec_t [`RN_WIDTH-1:0] gnt_onehot; // one-hot grant per slot

    // peel off the lowest set bit once per slot
    always_comb begin
        phys_reg_vec_t remaining;
        remaining = req;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            gnt_onehot[s] = remaining & (~remaining + phys_reg_vec_t'(1)); // isolate lowest one
            remaining     = remaining & ~gnt_onehot[s];                    // drop it for next slot
            pick_valid[s] = |gnt_onehot[s];                                // nothing left -> no grant
        end
    end

    // one-hot to binary, OR of the indices of set bits
    // grant is one-hot so at most one term contributes
    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            pick_reg[s] = '0;
            for (int b = 0; b < `PHYS_REG_SZ; b++) begin
                if (gnt_onehot[s][b]) begin
                    pick_reg[s] = pick_reg[s] | phys_reg_idx_t'(b);
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/map_table.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// architectural to physical mapping
// RN_WIDTH combinational read ports, RN_WIDTH write ports at the clock edge
module map_table
    import rename_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // read side, gives T_old before this cycle's writes
    input  arch_reg_idx_t [`RN_WIDTH-1:0]   read_arch,
    output phys_reg_idx_t [`RN_WIDTH-1:0]   read_phys,

    // write side, new mapping from rename
    input  logic          [`RN_WIDTH-1:0]   write_en,
    input  arch_reg_idx_t [`RN_WIDTH-1:0]   write_arch,
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   write_phys
);

    phys_reg_idx_t map_entry [`ARCH_REG_SZ]; // one physical tag per arch reg

    // read ports see the registered table only
    // bypass between slots of one group lives in the rename stage
    always_comb begin
        for (int s = 0; s < `RN_WIDTH; s++) begin
            read_phys[s] = map_entry[read_arch[s]];
        end
    end

    // identity at reset, arch r lives in phys r
    // slots written in order, so the higher slot wins on a clash
    always_ff @(posedge clock) begin
        if (reset) begin
            for (int a = 0; a < `ARCH_REG_SZ; a++) begin
                map_entry[a] <= phys_reg_idx_t'(a);
            end
        end else begin
            for (int s = 0; s < `RN_WIDTH; s++) begin
                if (write_en[s]) begin
                    map_entry[write_arch[s]] <= write_phys[s]; // later slot overrides
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/reg_status_lists.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// free list and complete list state for the physical register file
//   free list     <- dispatch clears, retire sets, mispredict restore ORs snapshot in
//   complete list <- completion sets, dispatch clears
module reg_status_lists
    import rename_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // from execute
    input  logic          [`RN_WIDTH-1:0]   completing_valid,  // per-slot strobe
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   completing_reg,    // T_new being written back

    // from retire
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   retiring_reg,      // T_old being released
    input  rn_cnt_t                         num_retiring,      // entries below this are valid

    // from branch recovery
    input  phys_reg_vec_t                   free_list_restore, // snapshot at the branch
    input  logic                            restore_flag,      // mispredict this cycle

    // from rename stage
    input  phys_reg_vec_t                   updated_free_list, // free list minus allocations

    output phys_reg_vec_t                   free_list,
    output phys_reg_vec_t                   complete_list,
    output phys_reg_vec_t                   next_complete_list // same-cycle view for issue
);

    // reset split, arch regs are mapped 1:1 and already hold values
    localparam phys_reg_vec_t free_reset_value =
        {{(`PHYS_REG_SZ - `ARCH_REG_SZ){1'b1}}, {`ARCH_REG_SZ{1'b0}}};
    localparam phys_reg_vec_t complete_reset_value = ~free_reset_value;

    phys_reg_vec_t allocated_regs;  // bits taken by dispatch this cycle
    phys_reg_vec_t retired_regs;    // bits returned by retire this cycle
    phys_reg_vec_t next_free_list;

    // dispatch only clears bits, so the difference is the new allocations
    assign allocated_regs = free_list & ~updated_free_list;

    // decode retire port into a bit vector
    always_comb begin
        retired_regs = '0;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (rn_cnt_t'(s) < num_retiring) begin
                retired_regs[retiring_reg[s]] = 1'b1;
            end
        end
    end

    // completions set bits, fresh allocations lose theirs
    always_comb begin
        next_complete_list = complete_list;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (completing_valid[s]) begin
                next_complete_list[completing_reg[s]] = 1'b1;
            end
        end
        next_complete_list = next_complete_list & ~allocated_regs; // new T_new not yet written
    end

    // retired regs come back, snapshot ORed in on mispredict
    always_comb begin
        next_free_list = updated_free_list | retired_regs;
        if (restore_flag) begin
            next_free_list = next_free_list | free_list_restore;
        end
    end

    always_ff @(posedge clock) begin
        if (reset) begin
            free_list     <= free_reset_value;
            complete_list <= complete_reset_value;
        end else begin
            free_list     <= next_free_list;
            complete_list <= next_complete_list;
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_pkg.sv ====
`default_nettype none

`include "rename_params.svh"

package rename_pkg;

    // index into the physical register file
    typedef logic [`PHYS_REG_ID_BITS-1:0] phys_reg_idx_t;

    // index into the architectural register file
    typedef logic [`ARCH_REG_ID_BITS-1:0] arch_reg_idx_t;

    // one bit per physical register
    // free list, complete list and branch snapshot all use this
    typedef logic [`PHYS_REG_SZ-1:0] phys_reg_vec_t;

    // number of entries valid on the retire port
    typedef logic [`RN_CNT_BITS-1:0] rn_cnt_t;

endpackage

`default_nettype wire

// ==== verilog/rename_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// per-slot rename for one dispatch group
// slot i takes pick i so slots must be packed from slot 0
module rename_stage
    import rename_pkg::*;
(
    input  logic          [`RN_WIDTH-1:0]   dispatch_valid,
    input  arch_reg_idx_t [`RN_WIDTH-1:0]   dest_arch,

    // from picker
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   pick_reg,
    input  logic          [`RN_WIDTH-1:0]   pick_valid,
    input  phys_reg_vec_t                   free_list,

    // map table read
    output arch_reg_idx_t [`RN_WIDTH-1:0]   read_arch,
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   read_phys,

    // map table write
    output logic          [`RN_WIDTH-1:0]   write_en,
    output arch_reg_idx_t [`RN_WIDTH-1:0]   write_arch,
    output phys_reg_idx_t [`RN_WIDTH-1:0]   write_phys,

    output phys_reg_idx_t [`RN_WIDTH-1:0]   t_new,
    output phys_reg_idx_t [`RN_WIDTH-1:0]   t_old,
    output phys_reg_vec_t                   updated_free_list,
    output logic                            dispatch_ready
);

    // every valid slot needs a grant or the whole group waits
    always_comb begin
        dispatch_ready = 1'b1;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (dispatch_valid[s] && !pick_valid[s]) begin
                dispatch_ready = 1'b0;
            end
        end
    end

    assign t_new      = pick_reg;
    assign read_arch  = dest_arch;  // look up current mapping of the dest
    assign write_arch = dest_arch;
    assign write_phys = pick_reg;
    assign write_en   = dispatch_valid & {`RN_WIDTH{dispatch_ready}}; // no writes when stalled

    // T_old comes from the table unless an older slot in the group has the same dest
    always_comb begin
        for (int i = 0; i < `RN_WIDTH; i++) begin
            t_old[i] = read_phys[i];
            for (int j = 0; j < i; j++) begin
                if (dispatch_valid[j] && (dest_arch[j] == dest_arch[i])) begin
                    t_old[i] = pick_reg[j]; // nearest older slot wins
                end
            end
        end
    end

    // take allocated regs out of the free list
    always_comb begin
        updated_free_list = free_list;
        for (int s = 0; s < `RN_WIDTH; s++) begin
            if (write_en[s]) begin
                updated_free_list[pick_reg[s]] = 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// ==== verilog/rename_top.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rename_params.svh"

// rename core, picker + rename stage + map table + status lists
module rename_top
    import rename_pkg::*;
(
    input  logic                            clock,
    input  logic                            reset,

    // dispatch
    input  logic          [`RN_WIDTH-1:0]   dispatch_valid,
    input  arch_reg_idx_t [`RN_WIDTH-1:0]   dest_arch,
    output logic                            dispatch_ready,
    output phys_reg_idx_t [`RN_WIDTH-1:0]   t_new,
    output phys_reg_idx_t [`RN_WIDTH-1:0]   t_old,

    // completion
    input  logic          [`RN_WIDTH-1:0]   completing_valid,
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   completing_reg,

    // retire
    input  phys_reg_idx_t [`RN_WIDTH-1:0]   retiring_reg,
    input  rn_cnt_t                         num_retiring,

    // mispredict recovery
    input  logic                            restore_flag,
    input  phys_reg_vec_t                   free_list_restore,

    output phys_reg_vec_t                   free_list,
    output phys_reg_vec_t                   complete_list,
    output phys_reg_vec_t                   next_complete_list
);

    phys_reg_idx_t [`RN_WIDTH-1:0] pick_reg;
    logic          [`RN_WIDTH-1:0] pick_valid;
    arch_reg_idx_t [`RN_WIDTH-1:0] read_arch;
    phys_reg_idx_t [`RN_WIDTH-1:0] read_phys;
    logic          [`RN_WIDTH-1:0] write_en;
    arch_reg_idx_t [`RN_WIDTH-1:0] write_arch;
    phys_reg_idx_t [`RN_WIDTH-1:0] write_phys;
    phys_reg_vec_t                 updated_free_list;

    free_reg_picker u_picker (
        .req        (free_list),
        .pick_reg   (pick_reg),
        .pick_valid (pick_valid)
    );

    rename_stage u_rename (
        .dispatch_valid    (dispatch_valid),
        .dest_arch         (dest_arch),
        .pick_reg          (pick_reg),
        .pick_valid        (pick_valid),
        .free_list         (free_list),
        .read_arch         (read_arch),
        .read_phys         (read_phys),
        .write_en          (write_en),
        .write_arch        (write_arch),
        .write_phys        (write_phys),
        .t_new             (t_new),
        .t_old             (t_old),
        .updated_free_list (updated_free_list),
        .dispatch_ready    (dispatch_ready)
    );

    map_table u_map (
        .clock      (clock),
        .reset      (reset),
        .read_arch  (read_arch),
        .read_phys  (read_phys),
        .write_en   (write_en),
        .write_arch (write_arch),
        .write_phys (write_phys)
    );

    reg_status_lists u_lists (
        .clock              (clock),
        .reset              (reset),
        .completing_valid   (completing_valid),
        .completing_reg     (completing_reg),
        .retiring_reg       (retiring_reg),
        .num_retiring       (num_retiring),
        .free_list_restore  (free_list_restore),
        .restore_flag       (restore_flag),
        .updated_free_list  (updated_free_list),
        .free_list          (free_list),
        .complete_list      (complete_list),
        .next_complete_list (next_complete_list)
    );

endmodule

`default_nettype wire
